// File: Bender.yml
package:
  name: pipelineCpu

sources:
  - design/cpuPkg.sv
  - design/registerFile.sv
  - design/hazardUnit.sv
  - design/fetchDecode.sv
  - design/executeStage.sv
  - design/memoryStage.sv
  - design/pipelineCpu.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/cpuTb.sv

// File: design/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// main opcodes, only the ones this core decodes
	typedef enum logic [5:0]
	{
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_t;

	// r-type funct field
	typedef enum logic [5:0]
	{
		FN_SLL = 6'h00,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_t;

	// alu operation select
	typedef enum logic [3:0]
	{
		ALU_AND = 4'b0000,
		ALU_OR  = 4'b0001,
		ALU_ADD = 4'b0010,
		ALU_SUB = 4'b0110,
		ALU_SLT = 4'b0111,
		ALU_SLL = 4'b1000
	} aluOp_t;

	// main control class for alu control
	localparam logic [1:0] ALUOP_ADD   = 2'b00; // address calc and addi
	localparam logic [1:0] ALUOP_RTYPE = 2'b10; // look at funct

	typedef enum logic [1:0]
	{
		FWD_NONE  = 2'b00,
		FWD_EXMEM = 2'b01,
		FWD_MEMWB = 2'b10
	} fwdSel_t;

	typedef struct packed
	{
		opcode_t    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_t     funct;
	} rType_t;

	typedef struct packed
	{
		opcode_t     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iType_t;

	// same word, two field layouts
	typedef union packed
	{
		rType_t rType;
		iType_t iType;
	} instr_t;

	typedef struct packed
	{
		logic       regWrite;
		logic       regDst;   // 1 = rd, 0 = rt
		logic       aluSrc;   // 1 = immediate
		logic       memRead;
		logic       memWrite;
		logic       memToReg;
		logic [1:0] aluOp;
	} ctrl_t;

	typedef struct packed
	{
		ctrl_t       ctrl;
		instr_t      instr;
		logic [31:0] rsData;
		logic [31:0] rtData;
		logic [31:0] immExt;
	} decoded_t;

	typedef struct packed
	{
		ctrl_t       ctrl;
		logic [4:0]  writeReg;
		logic [4:0]  rt;        // store source, for the lw/sw forward check
		logic [31:0] aluResult;
		logic [31:0] storeData;
	} exMem_t;

	typedef struct packed
	{
		logic        valid;   // regWrite and not r0
		logic [4:0]  regAddr;
		logic [31:0] data;
	} wb_t;

	localparam logic [31:0] NOP_WORD = 32'h0000_0000; // sll r0,r0,0

endpackage

`default_nettype wire

// File: design/executeStage.sv
`timescale 1ns/10ps
`default_nettype none

module executeStage (
	input  wire                    clk,
	input  wire                    rst,
	input  wire  cpuPkg::decoded_t decoded,
	input  wire  cpuPkg::fwdSel_t  fwdRs,
	input  wire  cpuPkg::fwdSel_t  fwdRt,
	input  wire  [31:0]            memWbData,
	output cpuPkg::decoded_t       exDecoded,
	output cpuPkg::exMem_t         exMem
);

	import cpuPkg::*;

	decoded_t    idEx;     // ID/EX register
	aluOp_t      aluSel;
	logic [31:0] rsFwd;    // operands after forwarding
	logic [31:0] rtFwd;
	logic [31:0] opB;
	logic [31:0] aluResult;
	logic [4:0]  writeReg;

	function automatic logic [31:0] fwdMux(input fwdSel_t sel, input logic [31:0] regVal);
		case (sel)
			FWD_EXMEM: return exMem.aluResult;
			FWD_MEMWB: return memWbData;
			default:   return regVal;
		endcase
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			idEx.ctrl  <= '0;
			idEx.instr <= NOP_WORD;
		end
		else
			idEx <= decoded; // stall bubble already has ctrl cleared
	end

	assign exDecoded = idEx;

	always_comb
	begin
		rsFwd = fwdMux(fwdRs, idEx.rsData);
		rtFwd = fwdMux(fwdRt, idEx.rtData);
		opB   = idEx.ctrl.aluSrc ? idEx.immExt : rtFwd;
	end

	// alu control
	always_comb
	begin
		aluSel = ALU_ADD; // lw, sw, addi
		if (idEx.ctrl.aluOp == ALUOP_RTYPE)
		begin
			case (idEx.instr.rType.funct)
				FN_ADD:  aluSel = ALU_ADD;
				FN_SUB:  aluSel = ALU_SUB;
				FN_AND:  aluSel = ALU_AND;
				FN_OR:   aluSel = ALU_OR;
				FN_SLT:  aluSel = ALU_SLT;
				FN_SLL:  aluSel = ALU_SLL;
				default: aluSel = ALU_ADD;
			endcase
		end
	end

	always_comb
	begin
		case (aluSel)
			ALU_ADD: aluResult = rsFwd + opB;
			ALU_SUB: aluResult = rsFwd - opB;
			ALU_AND: aluResult = rsFwd & opB;
			ALU_OR:  aluResult = rsFwd | opB;
			ALU_SLT: aluResult = {31'd0, $signed(rsFwd) < $signed(opB)};
			ALU_SLL: aluResult = opB << idEx.instr.rType.shamt; // rt shifted
			default: aluResult = 32'd0;
		endcase
	end

	assign writeReg = idEx.ctrl.regDst ? idEx.instr.rType.rd : idEx.instr.rType.rt;

	// EX/MEM register
	always_ff @(posedge clk)
	begin
		if (rst)
			exMem.ctrl <= '0;
		else
			exMem <= '{ctrl: idEx.ctrl, writeReg: writeReg, rt: idEx.instr.iType.rt,
				aluResult: aluResult, storeData: rtFwd};
	end

endmodule

`default_nettype wire

// File: design/fetchDecode.sv
`timescale 1ns/10ps
`default_nettype none

module fetchDecode (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    stall,
	input  wire  cpuPkg::instr_t   imemData,
	input  wire  [31:0]            rsData,
	input  wire  [31:0]            rtData,
	output logic [31:0]            imemAddr,
	output cpuPkg::instr_t         idInstr,
	output logic [4:0]             rsAddr,
	output logic [4:0]             rtAddr,
	output cpuPkg::decoded_t       decoded
);

	import cpuPkg::*;

	logic [31:0] pc;
	instr_t      ifId;   // IF/ID instruction
	ctrl_t       ctrl;
	logic [31:0] immExt;

	// pc and IF/ID hold together on a stall
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc   <= 32'd0;
			ifId <= NOP_WORD;
		end
		else if (!stall)
		begin
			pc   <= pc + 32'd4; // no branches, straight-line fetch
			ifId <= imemData;
		end
	end

	assign imemAddr = pc;
	assign idInstr  = ifId;
	assign rsAddr   = ifId.rType.rs;
	assign rtAddr   = ifId.rType.rt;

	// main control
	always_comb
	begin
		ctrl = '0; // also the bubble
		if (!stall)
		begin
			case (ifId.rType.opcode)
				OP_RTYPE:
				begin
					ctrl.regWrite = 1'b1;
					ctrl.regDst   = 1'b1;
					ctrl.aluOp    = ALUOP_RTYPE;
				end
				OP_ADDI:
				begin
					ctrl.regWrite = 1'b1;
					ctrl.aluSrc   = 1'b1;
				end
				OP_LW:
				begin
					ctrl.regWrite = 1'b1;
					ctrl.aluSrc   = 1'b1;
					ctrl.memRead  = 1'b1;
					ctrl.memToReg = 1'b1;
				end
				OP_SW:
				begin
					ctrl.aluSrc   = 1'b1;
					ctrl.memWrite = 1'b1;
				end
				default: ctrl = '0; // unknown opcode acts as nop
			endcase
		end
	end

	assign immExt = {{16{ifId.iType.imm[15]}}, ifId.iType.imm};

	assign decoded = '{ctrl: ctrl, instr: ifId, rsData: rsData, rtData: rtData,
		immExt: immExt};

endmodule

`default_nettype wire

// File: design/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
	input  wire  cpuPkg::instr_t   idInstr,   // IF/ID
	input  wire  cpuPkg::decoded_t exDecoded, // ID/EX
	input  wire  cpuPkg::exMem_t   exMem,
	input  wire  cpuPkg::wb_t      memWb,
	output logic                   stall,
	output cpuPkg::fwdSel_t        fwdRs,
	output cpuPkg::fwdSel_t        fwdRt,
	output logic                   storeFwd
);

	import cpuPkg::*;

	logic [4:0] loadDst;  // rt of the load in EX
	logic       usesRt;   // rt is an alu source in ID
	logic       rsHit;
	logic       rtHit;

	// younger EX/MEM result wins over MEM/WB
	function automatic fwdSel_t pickFwd(input logic [4:0] src);
		if (exMem.ctrl.regWrite && exMem.writeReg != 5'd0 && exMem.writeReg == src)
			return FWD_EXMEM;
		else if (memWb.valid && memWb.regAddr == src)
			return FWD_MEMWB; // valid already excludes r0
		else
			return FWD_NONE;
	endfunction

	// load-use: one bubble, then MEM/WB forward covers it
	// sw data in rt is caught later by storeFwd, so only r-type counts rt
	always_comb
	begin
		loadDst = exDecoded.instr.iType.rt;
		usesRt  = (idInstr.rType.opcode == OP_RTYPE);
		rsHit   = (loadDst == idInstr.rType.rs);
		rtHit   = usesRt && (loadDst == idInstr.rType.rt);
		stall   = exDecoded.ctrl.memRead && (loadDst != 5'd0) && (rsHit || rtHit);
	end

	always_comb
	begin
		fwdRs = pickFwd(exDecoded.instr.rType.rs);
		fwdRt = pickFwd(exDecoded.instr.rType.rt);
	end

	// lw then sw of same reg, load data arrives one stage late
	always_comb
	begin
		storeFwd = exMem.ctrl.memWrite && memWb.valid && (memWb.regAddr == exMem.rt);
	end

endmodule

`default_nettype wire

// File: design/memoryStage.sv
`timescale 1ns/10ps
`default_nettype none

module memoryStage #(
	parameter int dmemWords = 256
) (
	input  wire                  clk,
	input  wire                  rst,
	input  wire  cpuPkg::exMem_t exMem,
	input  wire                  storeFwd,
	output cpuPkg::wb_t          wb,
	output logic [31:0]          memWbData
);

	localparam int idxBits = $clog2(dmemWords);

	logic [31:0]        dmem [dmemWords];
	logic [idxBits-1:0] wordIdx;
	logic [31:0]        storeData;
	logic [31:0]        loadData;

	// MEM/WB state
	logic        mwValid;
	logic [4:0]  mwReg;
	logic        mwMemToReg;
	logic [31:0] mwAlu;
	logic [31:0] mwLoad;

	assign wordIdx   = exMem.aluResult[idxBits+1:2]; // byte addr to word
	assign loadData  = dmem[wordIdx];                 // async read
	assign storeData = storeFwd ? memWbData : exMem.storeData;

	always_ff @(posedge clk)
	begin
		if (!rst && exMem.ctrl.memWrite)
			dmem[wordIdx] <= storeData;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			mwValid <= 1'b0;
		else
			mwValid <= exMem.ctrl.regWrite && (exMem.writeReg != 5'd0);
		mwReg      <= exMem.writeReg;
		mwMemToReg <= exMem.ctrl.memToReg;
		mwAlu      <= exMem.aluResult;
		mwLoad     <= loadData;
	end

	// write-back mux
	assign memWbData = mwMemToReg ? mwLoad : mwAlu;
	assign wb        = '{valid: mwValid, regAddr: mwReg, data: memWbData};

endmodule

`default_nettype wire

// File: design/pipelineCpu.sv
`timescale 1ns/10ps
`default_nettype none

module pipelineCpu #(
	parameter int dmemWords = 256
) (
	input  wire                  clk,
	input  wire                  rst,
	input  wire  cpuPkg::instr_t imemData,
	output logic [31:0]          imemAddr,
	output cpuPkg::wb_t          wbOut
);

	import cpuPkg::*;

	instr_t      idInstr;
	logic [4:0]  rsAddr;
	logic [4:0]  rtAddr;
	logic [31:0] rsData;
	logic [31:0] rtData;
	decoded_t    decoded;    // decode to ID/EX
	decoded_t    exDecoded;  // ID/EX contents
	exMem_t      exMem;
	logic [31:0] memWbData;
	logic        stall;
	fwdSel_t     fwdRs;
	fwdSel_t     fwdRt;
	logic        storeFwd;

	fetchDecode fetch (
		.clk(clk), .rst(rst), .stall(stall), .imemData(imemData),
		.rsData(rsData), .rtData(rtData), .imemAddr(imemAddr),
		.idInstr(idInstr), .rsAddr(rsAddr), .rtAddr(rtAddr), .decoded(decoded)
	);

	registerFile regs (
		.clk(clk), .rst(rst), .rsAddr(rsAddr), .rtAddr(rtAddr),
		.wb(wbOut), .rsData(rsData), .rtData(rtData)
	);

	hazardUnit hazard (
		.idInstr(idInstr), .exDecoded(exDecoded), .exMem(exMem), .memWb(wbOut),
		.stall(stall), .fwdRs(fwdRs), .fwdRt(fwdRt), .storeFwd(storeFwd)
	);

	executeStage execute (
		.clk(clk), .rst(rst), .decoded(decoded), .fwdRs(fwdRs), .fwdRt(fwdRt),
		.memWbData(memWbData), .exDecoded(exDecoded), .exMem(exMem)
	);

	// wb output doubles as the regfile write port and the MEM/WB forward source
	memoryStage #(
		.dmemWords(dmemWords)
	) memory (
		.clk(clk), .rst(rst), .exMem(exMem), .storeFwd(storeFwd),
		.wb(wbOut), .memWbData(memWbData)
	);

endmodule

`default_nettype wire

// File: design/registerFile.sv
`timescale 1ns/10ps
`default_nettype none

module registerFile (
	input  wire               clk,
	input  wire               rst,
	input  wire  [4:0]        rsAddr,
	input  wire  [4:0]        rtAddr,
	input  wire  cpuPkg::wb_t wb,
	output logic [31:0]       rsData,
	output logic [31:0]       rtData
);

	logic [31:0] regs [1:31]; // r0 has no storage

	// read port with write-through from the wb port
	function automatic logic [31:0] readPort(input logic [4:0] addr);
		if (addr == 5'd0)
			return 32'd0;
		else if (wb.valid && wb.regAddr == addr)
			return wb.data; // same-cycle write
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= 32'd0;
		end
		else if (wb.valid)
			regs[wb.regAddr] <= wb.data; // valid never set for r0
	end

	always_comb
	begin
		rsData = readPort(rsAddr);
		rtData = readPort(rtAddr);
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+tests
design/cpuPkg.sv
design/registerFile.sv
design/hazardUnit.sv
design/fetchDecode.sv
design/executeStage.sv
design/memoryStage.sv
design/pipelineCpu.sv
tests/cpuTb.sv

// File: tests/cpuProgram.svh
task automatic buildProgram();
	// one row per instruction in fetch order from address 0
	// the model fills in each expected register and value
	// addi immediates of 0 are placeholders for xorshift values

	// seed registers then independent alu ops
	addStep("addi r1", iWord(OP_ADDI, 5'd1, 5'd0, 16'd0));
	addStep("addi r2", iWord(OP_ADDI, 5'd2, 5'd0, 16'd0));
	addStep("addi r3", iWord(OP_ADDI, 5'd3, 5'd0, 16'd0));
	addStep("addi r4", iWord(OP_ADDI, 5'd4, 5'd0, 16'd0));
	addStep("addi r5 from r1", iWord(OP_ADDI, 5'd5, 5'd1, 16'd0));
	addStep("add r6", rWord(FN_ADD, 5'd6, 5'd1, 5'd2, 5'd0));
	addStep("sub r7", rWord(FN_SUB, 5'd7, 5'd3, 5'd4, 5'd0));
	addStep("and r8", rWord(FN_AND, 5'd8, 5'd1, 5'd3, 5'd0));
	addStep("or r9", rWord(FN_OR, 5'd9, 5'd2, 5'd4, 5'd0));
	addStep("slt r10", rWord(FN_SLT, 5'd10, 5'd3, 5'd1, 5'd0));
	addStep("sll r11", rWord(FN_SLL, 5'd11, 5'd0, 5'd2, 5'd7));

	// dependency chain at distance 1, 2 and 3
	addStep("chain add r12", rWord(FN_ADD, 5'd12, 5'd1, 5'd2, 5'd0));
	addStep("dist1 sub r13", rWord(FN_SUB, 5'd13, 5'd12, 5'd3, 5'd0));
	addStep("dist2 and r14", rWord(FN_AND, 5'd14, 5'd12, 5'd13, 5'd0));
	addStep("dist3 or r15", rWord(FN_OR, 5'd15, 5'd12, 5'd14, 5'd0));
	addStep("dist1 addi r16", iWord(OP_ADDI, 5'd16, 5'd15, 16'd0));
	addStep("dist1 slt r17", rWord(FN_SLT, 5'd17, 5'd16, 5'd15, 5'd0));

	// memory and load-use stall
	addStep("sw r6", iWord(OP_SW, 5'd6, 5'd0, 16'd16));
	addStep("sw r7", iWord(OP_SW, 5'd7, 5'd0, 16'd20));
	addStep("lw r18", iWord(OP_LW, 5'd18, 5'd0, 16'd16));
	loadUseAt = prog.size();
	addStep("load-use add r19", rWord(FN_ADD, 5'd19, 5'd18, 5'd1, 5'd0));

	// lw straight into sw of the same reg then a readback
	addStep("lw r20", iWord(OP_LW, 5'd20, 5'd0, 16'd20));
	addStep("sw r20 forwarded", iWord(OP_SW, 5'd20, 5'd0, 16'd24));
	addStep("lw r21 readback", iWord(OP_LW, 5'd21, 5'd0, 16'd24));

	// r0 as destination and source
	addStep("addi r0", iWord(OP_ADDI, 5'd0, 5'd5, 16'd0));
	addStep("add r0", rWord(FN_ADD, 5'd0, 5'd1, 5'd2, 5'd0));
	addStep("add r22 r0+r9", rWord(FN_ADD, 5'd22, 5'd0, 5'd9, 5'd0));
	addStep("add r23 r10+r0", rWord(FN_ADD, 5'd23, 5'd10, 5'd0, 5'd0));
	addStep("add r24", rWord(FN_ADD, 5'd24, 5'd23, 5'd22, 5'd0));
endtask

// File: tests/cpuTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTb;

	import cpuPkg::*;

	localparam int clkPeriod = 8;

	typedef struct
	{
		string       name;
		logic [31:0] word;
		logic [4:0]  expReg;   // 0 means no write-back
		logic [31:0] expVal;
	} step_t;

	logic        clk;
	logic        rst;
	instr_t      imemData;
	logic [31:0] imemAddr;
	wb_t         wbOut;

	step_t       prog [$];
	int          loadUseAt;   // the add that waits on a load
	logic [31:0] rngState;
	logic [31:0] expPc;       // expected fetch address
	logic [31:0] stallAddr;   // fetch address held by the load-use bubble
	logic        stallSeen;
	wb_t         seen;        // wbOut sampled on the falling edge

	pipelineCpu #(
		.dmemWords(256)
	) uut (
		.clk(clk), .rst(rst), .imemData(imemData), .imemAddr(imemAddr), .wbOut(wbOut)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic checkReg(input string name, input logic [4:0] expected,
		input logic [4:0] actual);
		if (actual !== expected)
			reportFailure($sformatf("MISMATCH %s: expected r%0d, actual r%0d",
				name, expected, actual));
	endtask

	task automatic checkData(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			reportFailure($sformatf("MISMATCH %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	task automatic checkAddr(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			reportFailure($sformatf("MISMATCH %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	// instruction encoders in MIPS field order
	function automatic logic [31:0] rWord(input funct_t fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] shamt);
		return {OP_RTYPE, rs, rt, rd, shamt, fn};
	endfunction

	function automatic logic [31:0] iWord(input opcode_t op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic addStep(input string name, input logic [31:0] word);
		prog.push_back('{name: name, word: word, expReg: 5'd0, expVal: 32'd0});
	endtask

	`include "cpuProgram.svh"

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic fillImmediates();
		logic [31:0] w;
		foreach (prog[i])
		begin
			w = prog[i].word;
			if (w[31:26] == OP_ADDI)
			begin
				rngState = xorshift(rngState);
				w[15:0]  = rngState[15:0]; // random signed immediate
				prog[i].word = w;
			end
		end
	endtask

	// sequential ISA model stepping one instruction at a time
	task automatic runModel();
		logic [31:0] regs [32];
		logic [31:0] dataMem [logic [31:0]]; // keyed by byte address
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] result;
		logic [4:0]  dest;
		logic        writes;
		for (int r = 0; r < 32; r++)
			regs[r] = 32'd0;
		foreach (prog[i])
		begin
			w      = prog[i].word;
			a      = regs[w[25:21]];
			b      = regs[w[20:16]];
			imm    = {{16{w[15]}}, w[15:0]};
			writes = 1'b1;
			dest   = w[20:16];  // rt unless r-type
			result = 32'd0;
			case (w[31:26])
				OP_RTYPE:
				begin
					dest = w[15:11];
					case (w[5:0])
						FN_ADD:  result = a + b;
						FN_SUB:  result = a - b;
						FN_AND:  result = a & b;
						FN_OR:   result = a | b;
						FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						FN_SLL:  result = b << w[10:6];
						default: reportFailure({"unknown funct code in program at ", prog[i].name});
					endcase
				end
				OP_ADDI: result = a + imm;
				OP_LW:
				begin
					if (!dataMem.exists(a + imm))
						reportFailure({"program loads an address never stored: ", prog[i].name});
					result = dataMem[a + imm];
				end
				OP_SW:
				begin
					writes         = 1'b0;
					dataMem[a + imm] = b;
				end
				default: reportFailure({"unknown opcode in program at ", prog[i].name});
			endcase
			if (writes && dest != 5'd0)
			begin
				regs[dest]      = result;
				prog[i].expReg  = dest;
				prog[i].expVal  = result;
			end
		end
	endtask

	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		if ((addr >> 2) < prog.size())
			return prog[addr >> 2].word;
		else
			return NOP_WORD; // past the end
	endfunction

	// sample on the falling edge then drive the fetched word
	task automatic step();
		@(negedge clk);
		seen = wbOut;
		if (rst)
		begin
			if (wbOut.valid !== 1'b0)
				reportFailure("wbOut.valid was not low while reset was held");
			checkAddr("fetch address in reset", 32'd0, imemAddr);
		end
		else if (expPc == stallAddr && !stallSeen)
		begin
			stallSeen = 1'b1; // pc holds one cycle for the load-use bubble
			checkAddr("fetch hold on load-use stall", expPc, imemAddr);
		end
		else
		begin
			expPc += 32'd4;
			checkAddr("fetch address", expPc, imemAddr);
		end
		imemData = fetchWord(imemAddr);
	endtask

	initial
	begin
		@(negedge rst);
		#((prog.size() + 20) * clkPeriod);
		reportFailure("timeout, the write-backs did not all arrive in time");
	end

	initial
	begin
		rst       = 1'b1;
		imemData  = NOP_WORD;
		rngState  = 32'd41878;
		stallSeen = 1'b0;
		expPc     = 32'd0;
		buildProgram();
		fillImmediates();
		runModel();
		stallAddr = 32'(loadUseAt + 1) * 32'd4;

		repeat (16) step();
		rst = 1'b0;
		step(); // first cycle out of reset has no write-back
		if (seen.valid !== 1'b0)
			reportFailure("wbOut.valid was high on the first cycle after reset");

		// writes come in program order and r0 or sw rows give none
		foreach (prog[i])
		begin
			if (prog[i].expReg != 5'd0)
			begin
				do
					step();
				while (seen.valid !== 1'b1);
				checkReg(prog[i].name, prog[i].expReg, seen.regAddr);
				checkData(prog[i].name, prog[i].expVal, seen.data);
			end
		end

		// trailing nops must stay quiet
		repeat (6)
		begin
			step();
			if (seen.valid !== 1'b0)
				reportFailure("unexpected write-back after the last instruction");
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire
